//--- src.f
axi_bridge_pkg.sv
axi_req_if.sv
req_dispatch.sv
wr_data_buf.sv
axi_rd_engine.sv
axi_wr_engine.sv
axi_bridge_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
tb_axi_bridge.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f src.f --top-module tb_axi_bridge -o sim_axi_bridge
./obj_dir/sim_axi_bridge

//--- tb_axi_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_bridge import axi_bridge_pkg::*; ();

    localparam int    NUM_ITER    = 100;
    localparam int    MAX_REQ     = 2 * NUM_ITER;
    localparam int    REQ_CYCLES  = 200;
    localparam int    CLK_NS      = 4;
    localparam resp_t RESP_SLVERR = 2'b10;

    logic       o_axi_aclk;
    logic       i_rst_n;
    logic       i_req_valid;
    logic       i_req_write;
    addr_t      i_req_addr;
    blen_t      i_req_len;
    logic       i_wbuf_we;
    blen_t      i_wbuf_idx;
    data_t      i_wbuf_data;
    logic       o_busy;
    logic       o_done;
    resp_t      o_resp;
    logic       o_rd_valid;
    data_t      o_rd_data;
    logic       o_rd_last;
    addr_t      m_araddr;
    logic [7:0] m_arlen;
    logic       m_arvalid;
    logic       m_arready;
    data_t      m_rdata;
    resp_t      m_rresp;
    logic       m_rlast;
    logic       m_rvalid;
    logic       m_rready;
    addr_t      m_awaddr;
    logic [7:0] m_awlen;
    logic       m_awvalid;
    logic       m_awready;
    data_t      m_wdata;
    logic       m_wlast;
    logic       m_wvalid;
    logic       m_wready;
    resp_t      m_bresp;
    logic       m_bvalid;
    logic       m_bready;

    logic [4:0]  stall;
    logic [31:0] lfsr_state;
    data_t       ram_model [256];
    data_t       wbuf_model [BUF_DEPTH];
    logic        is_write;
    logic        extra;
    logic [7:0]  word;
    blen_t       len;

    tb_clk_gen u_clk (
         .o_axi_aclk (o_axi_aclk)
     ,   .o_rst_n    (i_rst_n   )
    );

    axi_bridge_top DUT (
         .o_axi_aclk  (o_axi_aclk ),  .i_rst_n     (i_rst_n    )
     ,   .i_req_valid (i_req_valid),  .i_req_write (i_req_write)
     ,   .i_req_addr  (i_req_addr ),  .i_req_len   (i_req_len  )
     ,   .i_wbuf_we   (i_wbuf_we  ),  .i_wbuf_idx  (i_wbuf_idx )
     ,   .i_wbuf_data (i_wbuf_data),  .o_busy      (o_busy     )
     ,   .o_done      (o_done     ),  .o_resp      (o_resp     )
     ,   .o_rd_valid  (o_rd_valid ),  .o_rd_data   (o_rd_data  )
     ,   .o_rd_last   (o_rd_last  ),  .o_m_araddr  (m_araddr   )
     ,   .o_m_arlen   (m_arlen    ),  .o_m_arvalid (m_arvalid  )
     ,   .i_m_arready (m_arready  ),  .i_m_rdata   (m_rdata    )
     ,   .i_m_rresp   (m_rresp    ),  .i_m_rlast   (m_rlast    )
     ,   .i_m_rvalid  (m_rvalid   ),  .o_m_rready  (m_rready   )
     ,   .o_m_awaddr  (m_awaddr   ),  .o_m_awlen   (m_awlen    )
     ,   .o_m_awvalid (m_awvalid  ),  .i_m_awready (m_awready  )
     ,   .o_m_wdata   (m_wdata    ),  .o_m_wlast   (m_wlast    )
     ,   .o_m_wvalid  (m_wvalid   ),  .i_m_wready  (m_wready   )
     ,   .i_m_bresp   (m_bresp    ),  .i_m_bvalid  (m_bvalid   )
     ,   .o_m_bready  (m_bready   )
    );

    tb_axi_mem u_mem (
         .o_axi_aclk (o_axi_aclk),  .i_rst_n   (i_rst_n  ),  .i_stall   (stall    )
     ,   .i_araddr   (m_araddr  ),  .i_arlen   (m_arlen  ),  .i_arvalid (m_arvalid)
     ,   .o_arready  (m_arready ),  .o_rdata   (m_rdata  ),  .o_rresp   (m_rresp  )
     ,   .o_rlast    (m_rlast   ),  .o_rvalid  (m_rvalid ),  .i_rready  (m_rready )
     ,   .i_awaddr   (m_awaddr  ),  .i_awvalid (m_awvalid),  .o_awready (m_awready)
     ,   .i_wdata    (m_wdata   ),  .i_wlast   (m_wlast  ),  .i_wvalid  (m_wvalid )
     ,   .o_wready   (m_wready  ),  .o_bresp   (m_bresp  ),  .o_bvalid  (m_bvalid )
     ,   .i_bready   (m_bready  )
    );

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        bit_out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            val = {val[30:0], bit_out};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "first mismatch");
        end
    endtask

    // New slave stalls every cycle
    task automatic next_cycle();
        @(negedge o_axi_aclk);
        stall = 5'(rand_bits(5));
    endtask

    task automatic load_buffer(input blen_t n);
        for (int i = 0; i <= int'(n); i++) begin
            i_wbuf_we   = 1'b1;
            i_wbuf_idx  = blen_t'(i);
            i_wbuf_data = rand_bits(32);
            wbuf_model[blen_t'(i)] = i_wbuf_data;
            next_cycle();
        end
        i_wbuf_we = 1'b0;
    endtask

    task automatic run_request(input logic wr, input logic [7:0] w, input blen_t n,
                               input logic dup);
        int    cycles;
        int    beats;
        logic  prev_last;
        logic  got_done;
        resp_t exp_resp;
        addr_t exp_addr;
        exp_resp  = (w >= 8'd192) ? RESP_SLVERR : RESP_OKAY;
        exp_addr  = {22'd0, w, 2'b00};
        cycles    = 0;
        beats     = 0;
        prev_last = 1'b0;
        got_done  = 1'b0;
        check_value("o_busy", 32'(o_busy), 32'd0);
        i_req_valid = 1'b1;
        i_req_write = wr;
        i_req_addr  = exp_addr;
        i_req_len   = n;
        next_cycle();
        while (!got_done) begin
            if (cycles == 0) begin
                check_value("o_busy", 32'(o_busy), 32'd1);
                check_value("o_m_awvalid", 32'(m_awvalid), 32'd0);
                check_value("o_m_arvalid", 32'(m_arvalid), 32'd0);
            end
            // Address valid two cycles after acceptance
            if (cycles == 1) begin
                check_value("o_m_awvalid", 32'(m_awvalid), 32'(wr));
                check_value("o_m_arvalid", 32'(m_arvalid), 32'(!wr));
            end
            if (m_awvalid) begin
                check_value("o_m_awaddr", m_awaddr, exp_addr);
                check_value("o_m_awlen", 32'(m_awlen), 32'(n));
            end
            if (m_arvalid) begin
                check_value("o_m_araddr", m_araddr, exp_addr);
                check_value("o_m_arlen", 32'(m_arlen), 32'(n));
            end
            if (wr) begin
                check_value("o_rd_valid", 32'(o_rd_valid), 32'd0);
            end else if (o_rd_valid) begin
                check_value("o_rd_data", o_rd_data, ram_model[w + 8'(beats)]);
                check_value("o_rd_last", 32'(o_rd_last), 32'(beats == int'(n)));
                beats++;
            end
            if (o_done) begin
                got_done = 1'b1;
                check_value("o_resp", 32'(o_resp), 32'(exp_resp));
                check_value("o_busy", 32'(o_busy), 32'd0);
                if (!wr) begin
                    check_value("read beats", 32'(beats), 32'(n) + 32'd1);
                    check_value("o_rd_last before o_done", 32'(prev_last), 32'd1);
                end else if (exp_resp == RESP_OKAY) begin
                    for (int i = 0; i <= int'(n); i++) begin
                        ram_model[w + 8'(i)] = wbuf_model[blen_t'(i)];
                    end
                end
            end
            prev_last   = o_rd_valid & o_rd_last;
            // A second request while busy must be dropped
            i_req_valid = dup && (cycles == 1);
            if (i_req_valid) begin
                check_value("o_busy", 32'(o_busy), 32'd1);
                i_req_write = ~wr;
                i_req_addr  = {22'd0, 8'(rand_bits(8)), 2'b00};
            end
            if (cycles >= REQ_CYCLES) begin
                $display("Request at time %0t got no done within %0d cycles", $time, cycles);
                $display("Finished with errors");
                $fatal(1, "request timeout");
            end
            cycles++;
            next_cycle();
        end
        repeat (4) begin
            check_value("o_done", 32'(o_done), 32'd0);
            check_value("o_m_arvalid", 32'(m_arvalid), 32'd0);
            check_value("o_m_awvalid", 32'(m_awvalid), 32'd0);
            next_cycle();
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("mem[%0d]", i), u_mem.mem[8'(i)], ram_model[8'(i)]);
        end
    endtask

    initial begin
        lfsr_state  = 32'h609ce034;
        stall       = '0;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_addr  = '0;
        i_req_len   = '0;
        i_wbuf_we   = 1'b0;
        i_wbuf_idx  = '0;
        i_wbuf_data = '0;
        @(posedge i_rst_n);
        next_cycle();
        check_value("o_busy", 32'(o_busy), 32'd0);
        check_value("o_done", 32'(o_done), 32'd0);
        check_value("o_rd_valid", 32'(o_rd_valid), 32'd0);
        check_value("o_m_arvalid", 32'(m_arvalid), 32'd0);
        check_value("o_m_awvalid", 32'(m_awvalid), 32'd0);
        check_value("o_m_wvalid", 32'(m_wvalid), 32'd0);
        check_value("o_m_rready", 32'(m_rready), 32'd0);
        check_value("o_m_bready", 32'(m_bready), 32'd0);
        for (int i = 0; i < 256; i++) begin
            ram_model[8'(i)] = u_mem.mem[8'(i)];
        end
        for (int n = 0; n < NUM_ITER; n++) begin
            is_write = 1'(rand_bits(1));
            word     = 8'(rand_bits(8));
            len      = blen_t'(rand_bits(4));
            extra    = 1'(rand_bits(1));
            if (is_write) begin
                load_buffer(len);
                run_request(1'b1, word, len, extra);
                // Read back the same range
                run_request(1'b0, word, len, 1'b0);
            end else begin
                run_request(1'b0, word, len, extra);
            end
            compare_memory();
        end
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(MAX_REQ * REQ_CYCLES * CLK_NS);
        $display("Watchdog expired before all requests completed");
        $display("Finished with errors");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem import axi_bridge_pkg::*; (
     input  wire         o_axi_aclk
 ,   input  wire         i_rst_n
     // Stalls, bit 0 arready, 1 rvalid, 2 awready, 3 wready, 4 bvalid
 ,   input  wire [4:0]   i_stall

 ,   input  wire addr_t  i_araddr
 ,   input  wire [7:0]   i_arlen
 ,   input  wire         i_arvalid
 ,   output logic        o_arready
 ,   output data_t       o_rdata
 ,   output resp_t       o_rresp
 ,   output logic        o_rlast
 ,   output logic        o_rvalid
 ,   input  wire         i_rready

 ,   input  wire addr_t  i_awaddr
 ,   input  wire         i_awvalid
 ,   output logic        o_awready
 ,   input  wire data_t  i_wdata
 ,   input  wire         i_wlast
 ,   input  wire         i_wvalid
 ,   output logic        o_wready
 ,   output resp_t       o_bresp
 ,   output logic        o_bvalid
 ,   input  wire         i_bready
);

    localparam resp_t RESP_SLVERR = 2'b10;

    data_t      mem [256];
    logic [4:0] stall_q;
    logic [7:0] rd_word;
    logic [7:0] rd_len;
    logic [7:0] rd_cnt;
    logic [7:0] wr_word;
    logic       rd_active;
    logic       rd_err;
    logic       r_hs_q;
    logic       wr_err;
    logic       b_pend;
    logic       b_hs_q;

    always @(posedge o_axi_aclk) begin
        stall_q <= i_stall;
    end

    // All decisions at the falling edge, a handshake seen here completes
    // at the next rising edge since both sides are stable until then
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[8'(i)] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
        end
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rlast   = 1'b0;
        o_rdata   = '0;
        o_rresp   = RESP_OKAY;
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        o_bresp   = RESP_OKAY;
        rd_active = 1'b0;
        r_hs_q    = 1'b0;
        b_pend    = 1'b0;
        b_hs_q    = 1'b0;
        forever begin
            @(negedge o_axi_aclk);
            if (i_rst_n) begin
                // ------------------------------------------------------------------------
                // Read side, R ahead of AR so no beat precedes its address
                // ------------------------------------------------------------------------
                if (o_rvalid && r_hs_q) begin
                    o_rvalid = 1'b0;
                    rd_word  = rd_word + 8'd1;
                    rd_cnt   = rd_cnt + 8'd1;
                    if (o_rlast) begin
                        rd_active = 1'b0;
                    end
                end
                if (rd_active && !o_rvalid && !stall_q[1]) begin
                    o_rvalid = 1'b1;
                    o_rdata  = mem[rd_word];
                    o_rlast  = (rd_cnt == rd_len);
                    o_rresp  = rd_err ? RESP_SLVERR : RESP_OKAY;
                end
                r_hs_q    = o_rvalid && i_rready;
                o_arready = !stall_q[0];
                if (i_arvalid && o_arready) begin
                    rd_word   = i_araddr[9:2];
                    rd_len    = i_arlen;
                    rd_cnt    = 8'd0;
                    rd_err    = (i_araddr[9:8] == 2'b11);
                    rd_active = 1'b1;
                end

                // ------------------------------------------------------------------------
                // Write side, error bursts leave the memory alone
                // ------------------------------------------------------------------------
                if (o_bvalid && b_hs_q) begin
                    o_bvalid = 1'b0;
                end
                if (b_pend && !o_bvalid && !stall_q[4]) begin
                    o_bvalid = 1'b1;
                    o_bresp  = wr_err ? RESP_SLVERR : RESP_OKAY;
                    b_pend   = 1'b0;
                end
                b_hs_q   = o_bvalid && i_bready;
                o_wready = !stall_q[3];
                if (i_wvalid && o_wready) begin
                    if (!wr_err) begin
                        mem[wr_word] = i_wdata;
                    end
                    wr_word = wr_word + 8'd1;
                    if (i_wlast) begin
                        b_pend = 1'b1;
                    end
                end
                o_awready = !stall_q[2];
                if (i_awvalid && o_awready) begin
                    wr_word = i_awaddr[9:2];
                    wr_err  = (i_awaddr[9:8] == 2'b11);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
     output logic        o_axi_aclk
 ,   output logic        o_rst_n
);

    localparam int HALF_NS    = 2;
    localparam int RST_CYCLES = 16;

    initial begin
        o_axi_aclk = 1'b0;
        forever #HALF_NS o_axi_aclk = ~o_axi_aclk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_axi_aclk);
        @(negedge o_axi_aclk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- axi_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module axi_bridge_top import axi_bridge_pkg::*; (
     input  wire         o_axi_aclk
 ,   input  wire         i_rst_n

     // Host request
 ,   input  wire         i_req_valid
 ,   input  wire         i_req_write
 ,   input  wire addr_t  i_req_addr
 ,   input  wire blen_t  i_req_len

     // Write buffer load
 ,   input  wire         i_wbuf_we
 ,   input  wire blen_t  i_wbuf_idx
 ,   input  wire data_t  i_wbuf_data

     // Status and read data
 ,   output logic        o_busy
 ,   output logic        o_done
 ,   output resp_t       o_resp
 ,   output logic        o_rd_valid
 ,   output data_t       o_rd_data
 ,   output logic        o_rd_last

     // AXI master read
 ,   output addr_t       o_m_araddr
 ,   output logic [7:0]  o_m_arlen
 ,   output logic        o_m_arvalid
 ,   input  wire         i_m_arready
 ,   input  wire data_t  i_m_rdata
 ,   input  wire resp_t  i_m_rresp
 ,   input  wire         i_m_rlast
 ,   input  wire         i_m_rvalid
 ,   output logic        o_m_rready

     // AXI master write
 ,   output addr_t       o_m_awaddr
 ,   output logic [7:0]  o_m_awlen
 ,   output logic        o_m_awvalid
 ,   input  wire         i_m_awready
 ,   output data_t       o_m_wdata
 ,   output logic        o_m_wlast
 ,   output logic        o_m_wvalid
 ,   input  wire         i_m_wready
 ,   input  wire resp_t  i_m_bresp
 ,   input  wire         i_m_bvalid
 ,   output logic        o_m_bready
);

    axi_req_if rd_req_if ();
    axi_req_if wr_req_if ();

    blen_t buf_ridx;
    data_t buf_rdata;

    // ------------------------------------------------------------------------
    // Dispatcher and write buffer
    // ------------------------------------------------------------------------
    req_dispatch u_dispatch (
         .o_axi_aclk   (o_axi_aclk  )
     ,   .i_rst_n      (i_rst_n     )
     ,   .i_req_valid  (i_req_valid )
     ,   .i_req_write  (i_req_write )
     ,   .i_req_addr   (i_req_addr  )
     ,   .i_req_len    (i_req_len   )
     ,   .o_busy       (o_busy      )
     ,   .o_done       (o_done      )
     ,   .o_resp       (o_resp      )
     ,   .rd_req       (rd_req_if   )
     ,   .wr_req       (wr_req_if   )
    );

    wr_data_buf u_wbuf (
         .o_axi_aclk   (o_axi_aclk  )
     ,   .i_we         (i_wbuf_we   )
     ,   .i_widx       (i_wbuf_idx  )
     ,   .i_wdata      (i_wbuf_data )
     ,   .i_ridx       (buf_ridx    )
     ,   .o_rdata      (buf_rdata   )
    );

    // ------------------------------------------------------------------------
    // Master engines
    // ------------------------------------------------------------------------
    axi_rd_engine u_rd_engine (
         .o_axi_aclk   (o_axi_aclk  )
     ,   .i_rst_n      (i_rst_n     )
     ,   .req          (rd_req_if   )
     ,   .o_m_araddr   (o_m_araddr  )
     ,   .o_m_arlen    (o_m_arlen   )
     ,   .o_m_arvalid  (o_m_arvalid )
     ,   .i_m_arready  (i_m_arready )
     ,   .i_m_rdata    (i_m_rdata   )
     ,   .i_m_rresp    (i_m_rresp   )
     ,   .i_m_rlast    (i_m_rlast   )
     ,   .i_m_rvalid   (i_m_rvalid  )
     ,   .o_m_rready   (o_m_rready  )
     ,   .o_rd_valid   (o_rd_valid  )
     ,   .o_rd_data    (o_rd_data   )
     ,   .o_rd_last    (o_rd_last   )
    );

    axi_wr_engine u_wr_engine (
         .o_axi_aclk   (o_axi_aclk  )
     ,   .i_rst_n      (i_rst_n     )
     ,   .req          (wr_req_if   )
     ,   .o_buf_idx    (buf_ridx    )
     ,   .i_buf_data   (buf_rdata   )
     ,   .o_m_awaddr   (o_m_awaddr  )
     ,   .o_m_awlen    (o_m_awlen   )
     ,   .o_m_awvalid  (o_m_awvalid )
     ,   .i_m_awready  (i_m_awready )
     ,   .o_m_wdata    (o_m_wdata   )
     ,   .o_m_wlast    (o_m_wlast   )
     ,   .o_m_wvalid   (o_m_wvalid  )
     ,   .i_m_wready   (i_m_wready  )
     ,   .i_m_bresp    (i_m_bresp   )
     ,   .i_m_bvalid   (i_m_bvalid  )
     ,   .o_m_bready   (o_m_bready  )
    );

endmodule

`default_nettype wire

//--- axi_wr_engine.sv
`timescale 1ns/1ns
`default_nettype none

module axi_wr_engine import axi_bridge_pkg::*; (
     input  wire         o_axi_aclk
 ,   input  wire         i_rst_n

 ,   axi_req_if.eng      req

     // Write buffer read port
 ,   output blen_t       o_buf_idx
 ,   input  wire data_t  i_buf_data

     // AW channel
 ,   output addr_t       o_m_awaddr
 ,   output logic [7:0]  o_m_awlen
 ,   output logic        o_m_awvalid
 ,   input  wire         i_m_awready

     // W channel
 ,   output data_t       o_m_wdata
 ,   output logic        o_m_wlast
 ,   output logic        o_m_wvalid
 ,   input  wire         i_m_wready

     // B channel
 ,   input  wire resp_t  i_m_bresp
 ,   input  wire         i_m_bvalid
 ,   output logic        o_m_bready
);

    wr_state_t state;
    blen_t     beat;
    blen_t     len_q;
    resp_t     resp_q;
    logic      w_hs;

    assign w_hs        = o_m_wvalid & i_m_wready;
    assign o_m_awvalid = (state == WR_ADDR);
    assign o_m_wvalid  = (state == WR_DATA);
    assign o_m_bready  = (state == WR_RESP);
    assign o_m_wlast   = (state == WR_DATA) && (beat == len_q);

    // Fetch the following word on each accepted beat, so the buffer
    // output already holds it in the next cycle
    assign o_buf_idx = w_hs ? beat + blen_t'(1) : beat;
    assign o_m_wdata = i_buf_data;

    assign req.done = (state == WR_DONE);
    assign req.resp = resp_q;

    always_ff @(posedge o_axi_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= WR_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (req.start) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (i_m_awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        if (o_m_wlast) begin
                            // Back to word 0 for the next burst
                            beat  <= '0;
                            state <= WR_RESP;
                        end else begin
                            beat <= beat + blen_t'(1);
                        end
                    end
                end
                WR_RESP: begin
                    if (i_m_bvalid) begin
                        state <= WR_DONE;
                    end
                end
                WR_DONE: state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Address and response payload
    // ------------------------------------------------------------------------
    always_ff @(posedge o_axi_aclk) begin
        if (state == WR_IDLE && req.start) begin
            o_m_awaddr <= req.addr;
            o_m_awlen  <= {{(8-LEN_W){1'b0}}, req.len};
            len_q      <= req.len;
        end
        if (o_m_bready && i_m_bvalid) begin
            resp_q <= i_m_bresp;
        end
    end

endmodule

`default_nettype wire

//--- axi_rd_engine.sv
`timescale 1ns/1ns
`default_nettype none

module axi_rd_engine import axi_bridge_pkg::*; (
     input  wire         o_axi_aclk
 ,   input  wire         i_rst_n

 ,   axi_req_if.eng      req

     // AR channel
 ,   output addr_t       o_m_araddr
 ,   output logic [7:0]  o_m_arlen
 ,   output logic        o_m_arvalid
 ,   input  wire         i_m_arready

     // R channel
 ,   input  wire data_t  i_m_rdata
 ,   input  wire resp_t  i_m_rresp
 ,   input  wire         i_m_rlast
 ,   input  wire         i_m_rvalid
 ,   output logic        o_m_rready

     // Beats to the requester
 ,   output logic        o_rd_valid
 ,   output data_t       o_rd_data
 ,   output logic        o_rd_last
);

    rd_state_t state;
    resp_t     resp_q;
    logic      done_q;
    logic      r_hs;

    assign r_hs        = o_m_rready & i_m_rvalid;
    assign o_m_arvalid = (state == RD_ADDR);
    assign o_m_rready  = (state == RD_DATA);

    assign req.done = done_q;
    assign req.resp = resp_q;

    always_ff @(posedge o_axi_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= RD_IDLE;
            resp_q     <= RESP_OKAY;
            done_q     <= 1'b0;
            o_rd_valid <= 1'b0;
            o_rd_last  <= 1'b0;
        end else begin
            // Done trails the last forwarded beat by one cycle
            done_q     <= (state == RD_DONE);
            o_rd_valid <= r_hs;
            o_rd_last  <= r_hs & i_m_rlast;
            case (state)
                RD_IDLE: begin
                    if (req.start) begin
                        resp_q <= RESP_OKAY;
                        state  <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (i_m_arready) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_hs) begin
                        // Worst response over the burst
                        if (i_m_rresp > resp_q) begin
                            resp_q <= i_m_rresp;
                        end
                        if (i_m_rlast) begin
                            state <= RD_DONE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Address and beat payload
    // ------------------------------------------------------------------------
    always_ff @(posedge o_axi_aclk) begin
        if (state == RD_IDLE && req.start) begin
            o_m_araddr <= req.addr;
            o_m_arlen  <= {{(8-LEN_W){1'b0}}, req.len};
        end
        if (r_hs) begin
            o_rd_data <= i_m_rdata;
        end
    end

endmodule

`default_nettype wire

//--- wr_data_buf.sv
`timescale 1ns/1ns
`default_nettype none

module wr_data_buf import axi_bridge_pkg::*; (
     input  wire         o_axi_aclk

     // Host load port
 ,   input  wire         i_we
 ,   input  wire blen_t  i_widx
 ,   input  wire data_t  i_wdata

     // Engine read port
 ,   input  wire blen_t  i_ridx
 ,   output data_t       o_rdata
);

    data_t mem [BUF_DEPTH];

    always_ff @(posedge o_axi_aclk) begin
        if (i_we) begin
            mem[i_widx] <= i_wdata;
        end
    end

    // Registered read, data one cycle after the index
    always_ff @(posedge o_axi_aclk) begin
        o_rdata <= mem[i_ridx];
    end

endmodule

`default_nettype wire

//--- req_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module req_dispatch import axi_bridge_pkg::*; (
     input  wire         o_axi_aclk
 ,   input  wire         i_rst_n

 ,   input  wire         i_req_valid
 ,   input  wire         i_req_write
 ,   input  wire addr_t  i_req_addr
 ,   input  wire blen_t  i_req_len

 ,   output logic        o_busy
 ,   output logic        o_done
 ,   output resp_t       o_resp

 ,   axi_req_if.disp     rd_req
 ,   axi_req_if.disp     wr_req
);

    logic  busy_q;
    logic  accept;
    logic  rd_start_q;
    logic  wr_start_q;
    addr_t addr_q;
    blen_t len_q;

    // Only one request in flight
    assign accept = i_req_valid & ~o_busy;

    // Completion merge, busy drops in the done cycle itself
    assign o_done = rd_req.done | wr_req.done;
    assign o_resp = wr_req.done ? wr_req.resp : rd_req.resp;
    assign o_busy = busy_q & ~o_done;

    assign rd_req.start = rd_start_q;
    assign rd_req.addr  = addr_q;
    assign rd_req.len   = len_q;

    assign wr_req.start = wr_start_q;
    assign wr_req.addr  = addr_q;
    assign wr_req.len   = len_q;

    always_ff @(posedge o_axi_aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q     <= 1'b0;
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
        end else begin
            rd_start_q <= accept & ~i_req_write;
            wr_start_q <= accept & i_req_write;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (o_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge o_axi_aclk) begin
        if (accept) begin
            addr_q <= i_req_addr;
            len_q  <= i_req_len;
        end
    end

endmodule

`default_nettype wire

//--- axi_req_if.sv
`timescale 1ns/1ns
`default_nettype none

// One dispatched request and its completion
interface axi_req_if import axi_bridge_pkg::*; ();

    logic  start;
    addr_t addr;
    blen_t len;

    logic  done;
    resp_t resp;

    // Dispatcher side
    modport disp (
        output start,
        output addr,
        output len,
        input  done,
        input  resp
    );

    // Engine side
    modport eng (
        input  start,
        input  addr,
        input  len,
        output done,
        output resp
    );

endinterface

`default_nettype wire

//--- axi_bridge_pkg.sv
`default_nettype none

package axi_bridge_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int BUF_DEPTH = 16;
    // Request length holds beats minus one
    localparam int LEN_W     = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  blen_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // ------------------------------------------------------------------------
    // Engine state machines
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_DONE
    } rd_state_t;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } wr_state_t;

endpackage

`default_nettype wire
